// ==== Bender.yml ====
package:
  name: connection_searcher

sources:
  - common/conn_pkg.sv
  - hdl/sync_fifo.sv
  - hdl/flow_key_hasher.sv
  - hdl/hash_matcher.sv
  - conn_search/table_wait_timer.sv
  - conn_search/tcp_state_update.sv
  - conn_search/conn_search_fsm.sv
  - hdl/connection_searcher.sv
  - target: simulation
    files:
      - dv/conn_table_model.sv
      - dv/tb_connection_searcher.sv

// ==== build.f ====
common/conn_pkg.sv
hdl/sync_fifo.sv
hdl/flow_key_hasher.sv
hdl/hash_matcher.sv
conn_search/table_wait_timer.sv
conn_search/tcp_state_update.sv
conn_search/conn_search_fsm.sv
hdl/connection_searcher.sv
dv/conn_table_model.sv
dv/tb_connection_searcher.sv

// ==== common/conn_pkg.sv ====
// shared types and constants of the connection searcher, imported by every block and the testbench
`default_nettype none

package conn_pkg;

	localparam logic [1:0] PKT_TAIL = 2'b10; // hd_tag of the last beat

	localparam logic [5:0] FLAG_FIN = 6'h01;
	localparam logic [5:0] FLAG_SYN = 6'h02;
	localparam logic [5:0] FLAG_RST = 6'h04;
	localparam logic [5:0] FLAG_ACK = 6'h10;

	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] src_port;
		logic [15:0] dst_port;
	} flow_key_t; // 96 bits

	typedef logic [5:0] tcp_flags_t;

	typedef struct packed {
		flow_key_t  key;
		tcp_flags_t flags;
	} key_rec_t; // key fifo payload

	typedef struct packed {
		logic [1:0]  hd_tag; // header/body/tail marker
		logic [3:0]  spare;
		flow_key_t   flow_key;
		tcp_flags_t  tcp_flags;
		logic [25:0] rest; // untouched here
	} meta_t; // 134-bit beat

	typedef logic [8:0]  conn_idx_t; // 0 is the null index
	typedef logic [15:0] sim_key_t;

	typedef struct packed {
		logic      valid;
		sim_key_t  sim_key;
		logic [6:0] spare;
		conn_idx_t idx;
	} hash_entry_t; // 33 bits

	typedef enum logic [1:0] {
		CLOSED      = 2'd0,
		REQUESTED   = 2'd1,
		ESTABLISHED = 2'd2
	} tcp_state_e;

	typedef struct packed {
		flow_key_t  flow_key;
		logic       dir; // side that opened the entry, 0 is client
		tcp_state_e cli_state;
		tcp_state_e ser_state;
		conn_idx_t  next_idx; // collision chain link
	} conn_entry_t; // 110 bits

	typedef struct packed {
		logic        aging; // entry timed out
		conn_entry_t entry;
	} conn_read_t;

	typedef struct packed {
		logic forward; // kept, never set
		logic pkt_in;
		logic reserved;
		logic conn_start;
		logic conn_end;
		logic state_change;
		logic time_out; // kept, never set
		logic conn_setup;
		logic new_flow;
		logic every_pkt;
	} event_map_t;

	typedef struct packed {
		logic [2:0] zero;
		logic       dir;
		tcp_state_e cli_state;
		tcp_state_e ser_state;
	} conn_state_t;

	typedef struct packed {
		logic [15:0] flow_id; // index in the low 9 bits
		conn_state_t state;
		logic [7:0]  events; // low half of event map
	} pkt_in_info_t;

endpackage

`default_nettype wire

// ==== conn_search/conn_search_fsm.sv ====
// searches the connection table for each queued index, walks the chain and reports the result
`timescale 1ns/1ps
`default_nettype none

module conn_search_fsm import conn_pkg::*; (
	input  wire              clk,
	input  wire              reset,
	input  wire              idx_empty,
	input  wire conn_idx_t   idx,
	input  wire key_rec_t    key_rec,
	output logic             fifo_rd,
	output logic             timer_start,
	input  wire              timer_done,
	input  wire conn_read_t  conn_rdata,
	output logic             conn_rd,
	output logic             conn_wr,
	output logic             aging_wr,
	output conn_idx_t        conn_idx,
	output logic             upd_load,
	output logic             upd_dir,
	output tcp_flags_t       upd_flags,
	input  wire conn_entry_t new_entry,
	input  wire              changed,
	input  wire event_map_t  trans_events,
	output logic             event_valid,
	output event_map_t       events,
	output pkt_in_info_t     pkt_in_info
);

	typedef enum logic [2:0] {
		st_idle, st_pop, st_wait, st_compare, st_update, st_report
	} search_state_e;

	search_state_e state;
	key_rec_t      key_q; // packet under search
	conn_read_t    rd_q; // latched table word
	flow_key_t     rev_key;
	logic          fwd_hit;
	logic          rev_hit;
	conn_state_t   upd_state;
	event_map_t    live_ev;

	function automatic event_map_t miss_events();
		event_map_t ev;
		ev = '0;
		ev.new_flow = 1'b1;
		ev.pkt_in = 1'b1; // only new flows go to the cpu
		return ev;
	endfunction

	function automatic pkt_in_info_t make_info(conn_idx_t id, conn_state_t st, event_map_t ev);
		pkt_in_info_t info;
		info.flow_id = {7'd0, id};
		info.state = st;
		info.events = ev[7:0];
		return info;
	endfunction

	assign fifo_rd = (state == st_pop); // key and index leave together
	assign upd_flags = key_q.flags;
	assign rev_key = '{key_q.key.dst_ip, key_q.key.src_ip, key_q.key.dst_port, key_q.key.src_port};
	assign fwd_hit = (key_q.key == rd_q.entry.flow_key);
	assign rev_hit = (rev_key == rd_q.entry.flow_key);
	assign upd_state = '{3'd0, new_entry.dir, new_entry.cli_state, new_entry.ser_state};

	always_comb begin
		live_ev = trans_events;
		live_ev.every_pkt = 1'b1;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			conn_rd <= 1'b0;
			timer_start <= 1'b0;
			conn_wr <= 1'b0;
			aging_wr <= 1'b0;
			conn_idx <= '0;
			upd_load <= 1'b0;
			upd_dir <= 1'b0;
			event_valid <= 1'b0;
			events <= '0;
			pkt_in_info <= '0;
		end else begin
			conn_rd <= 1'b0; // strobes fall after one cycle
			timer_start <= 1'b0;
			conn_wr <= 1'b0;
			aging_wr <= 1'b0;
			upd_load <= 1'b0;
			event_valid <= 1'b0;
			case (state)
				st_idle: if (!idx_empty) state <= st_pop;
				st_pop: begin
					conn_idx <= idx;
					if (idx == '0) begin // hash miss, no table access
						events <= miss_events();
						pkt_in_info <= make_info('0, '0, miss_events());
						state <= st_report;
					end else begin
						conn_rd <= 1'b1;
						timer_start <= 1'b1;
						state <= st_wait;
					end
				end
				st_wait: if (timer_done) state <= st_compare;
				st_compare: begin
					if (fwd_hit || rev_hit) begin
						if (rd_q.aging) begin // stale entry, treat as new
							events <= miss_events();
							pkt_in_info <= make_info(conn_idx, '0, miss_events());
							state <= st_report;
						end else begin
							aging_wr <= 1'b1; // refresh last-seen
							upd_load <= 1'b1;
							upd_dir <= rd_q.entry.dir ^ !fwd_hit; // reverse flips side
							state <= st_update;
						end
					end else if (rd_q.entry.next_idx != '0) begin
						conn_idx <= rd_q.entry.next_idx; // follow the chain
						conn_rd <= 1'b1;
						timer_start <= 1'b1;
						state <= st_wait;
					end else begin
						events <= miss_events();
						pkt_in_info <= make_info('0, '0, miss_events());
						state <= st_report;
					end
				end
				st_update: begin
					if (!upd_load) begin // updater output lands one cycle after load
						conn_wr <= changed; // updater entry is the write data
						events <= live_ev;
						pkt_in_info <= make_info(conn_idx, upd_state, live_ev);
						state <= st_report;
					end
				end
				st_report: begin
					event_valid <= 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_pop) key_q <= key_rec;
		if ((state == st_wait) && timer_done) rd_q <= conn_rdata;
	end

	// one table read in flight, next read only after the timer saw the data
	a_single_read: assert property (@(posedge clk) disable iff (!reset)
		conn_rd |=> (!conn_rd throughout timer_done [->1]));

endmodule

`default_nettype wire

// ==== conn_search/table_wait_timer.sv ====
// counts down the connection-table read latency and flags the cycle that carries read data
`timescale 1ns/1ps
`default_nettype none

module table_wait_timer #(
	parameter int latency = 3
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  start,
	output logic done
);

	localparam int cw = (latency > 1) ? $clog2(latency) : 1;

	logic [cw-1:0] cnt; // cycles left after this one
	logic          busy;

	assign done = busy && (cnt == '0);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt <= cw'(latency - 1); // start cycle already counts
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!reset) start |-> !busy);

endmodule

`default_nettype wire

// ==== conn_search/tcp_state_update.sv ====
// applies the client and server TCP transitions to a matched entry and registers the result
`timescale 1ns/1ps
`default_nettype none

module tcp_state_update import conn_pkg::*; (
	input  wire              clk,
	input  wire              reset,
	input  wire              load,
	input  wire conn_entry_t entry,
	input  wire              dir, // packet side, 0 is client
	input  wire tcp_flags_t  flags,
	output conn_entry_t      new_entry,
	output logic             changed,
	output event_map_t       trans_events
);

	conn_entry_t nxt;
	logic        chg;
	event_map_t  ev;

	always_comb begin
		nxt = entry;
		chg = 1'b0;
		ev = '0;
		if (!dir) begin
			case (entry.cli_state)
				REQUESTED: begin
					if (flags == FLAG_ACK) begin // handshake done
						nxt.cli_state = ESTABLISHED;
						nxt.ser_state = ESTABLISHED;
						chg = 1'b1;
						ev.conn_setup = 1'b1;
					end else if (|(flags & FLAG_RST)) begin
						nxt.cli_state = CLOSED;
						nxt.ser_state = CLOSED;
						chg = 1'b1;
						ev.conn_end = 1'b1;
					end
				end
				ESTABLISHED: begin
					if (|(flags & (FLAG_FIN | FLAG_RST))) begin
						nxt.cli_state = CLOSED;
						if (|(flags & FLAG_RST)) nxt.ser_state = CLOSED; // reset kills both sides
						chg = 1'b1;
						ev.conn_end = 1'b1;
					end
				end
				default: ; // closed client waits for the control plane
			endcase
		end else begin
			case (entry.ser_state)
				CLOSED: begin
					if (flags == (FLAG_SYN | FLAG_ACK)) begin
						nxt.ser_state = REQUESTED;
						chg = 1'b1;
						ev.conn_start = 1'b1;
					end
				end
				ESTABLISHED: begin
					if (|(flags & FLAG_FIN)) begin // half close, server side only
						nxt.ser_state = CLOSED;
						chg = 1'b1;
						ev.conn_end = 1'b1;
					end
				end
				default: ; // requested moves on the client ack
			endcase
		end
		ev.state_change = chg;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			changed <= 1'b0;
			trans_events <= '0;
		end else if (load) begin
			changed <= chg;
			trans_events <= ev;
		end
	end

	always_ff @(posedge clk) begin
		if (load) new_entry <= nxt; // held as write data
	end

endmodule

`default_nettype wire

// ==== dv/conn_table_model.sv ====
// behavioral hash tables and connection table with fixed read latencies, preloaded by the testbench
`timescale 1ns/1ps
`default_nettype none

module conn_table_model import conn_pkg::*; #(
	parameter int hash_rd_latency = 2,
	parameter int conn_rd_latency = 3
) (
	input  wire              clk,
	input  wire              reset,
	input  wire conn_idx_t   hash_1,
	input  wire conn_idx_t   hash_2,
	output hash_entry_t      hash_entry_1,
	output hash_entry_t      hash_entry_2,
	input  wire              conn_rd,
	input  wire              conn_wr,
	input  wire              aging_wr,
	input  wire conn_idx_t   conn_idx,
	input  wire conn_entry_t conn_wdata,
	output conn_read_t       conn_rdata
);

	hash_entry_t bucket_1 [512];
	hash_entry_t bucket_2 [512];
	conn_entry_t conn_mem [512];
	logic        aging_mem [512];
	hash_entry_t b1_pipe [hash_rd_latency]; // bucket data in flight
	hash_entry_t b2_pipe [hash_rd_latency];
	logic        rd_vld [conn_rd_latency-1]; // table read in flight
	conn_read_t  rd_pipe [conn_rd_latency-1];

	assign hash_entry_1 = b1_pipe[hash_rd_latency-1];
	assign hash_entry_2 = b2_pipe[hash_rd_latency-1];

	initial begin
		for (int i = 0; i < 512; i++) begin
			bucket_1[i] = '{1'b0, sim_key_t'(i), 7'd0, conn_idx_t'(i)}; // empty, not valid
			bucket_2[i] = '{1'b0, ~sim_key_t'(i), 7'd0, conn_idx_t'(i)};
			conn_mem[i] = '0;
			conn_mem[i].flow_key.src_ip = 32'hc0a8_0000 + i; // unused slots stay unique
			conn_mem[i].flow_key.dst_ip = ~32'(i);
			aging_mem[i] = 1'b0;
		end
		for (int i = 0; i < hash_rd_latency; i++) begin
			b1_pipe[i] = '0;
			b2_pipe[i] = '0;
		end
	end

	task automatic write_bucket(input int which, input conn_idx_t addr, input hash_entry_t e);
		if (which == 1) bucket_1[addr] = e;
		else bucket_2[addr] = e;
	endtask

	task automatic write_conn(input conn_idx_t idx, input logic aged, input conn_entry_t e);
		conn_mem[idx] = e;
		aging_mem[idx] = aged;
	endtask

	always @(posedge clk) begin
		b1_pipe[0] <= bucket_1[hash_1]; // looked up every cycle
		b2_pipe[0] <= bucket_2[hash_2];
		for (int i = 1; i < hash_rd_latency; i++) begin
			b1_pipe[i] <= b1_pipe[i-1];
			b2_pipe[i] <= b2_pipe[i-1];
		end
		rd_pipe[0] <= '{aging_mem[conn_idx], conn_mem[conn_idx]};
		for (int i = 1; i < conn_rd_latency - 1; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
		if (conn_wr) conn_mem[conn_idx] <= conn_wdata;
		if (aging_wr) aging_mem[conn_idx] <= 1'b0; // refreshed entry is live again
	end

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < conn_rd_latency - 1; i++) begin
				rd_vld[i] <= 1'b0;
			end
			conn_rdata <= '0;
		end else begin
			rd_vld[0] <= conn_rd;
			for (int i = 1; i < conn_rd_latency - 1; i++) begin
				rd_vld[i] <= rd_vld[i-1];
			end
			if (rd_vld[conn_rd_latency-2]) conn_rdata <= rd_pipe[conn_rd_latency-2]; // held till next read
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_connection_searcher.sv ====
// testbench that preloads the table model, streams packets into the searcher and checks each result
`timescale 1ns/1ps
`default_nettype none

module tb_connection_searcher import conn_pkg::*; ();

	localparam int N_ROWS = 11;
	localparam int TIMEOUT_CYCLES = 60 * N_ROWS + 100;
	localparam logic [1:0] TAG_HEAD = 2'b01;
	localparam logic [1:0] TAG_BODY = 2'b00;

	typedef struct {
		string        name;
		flow_key_t    key;
		tcp_flags_t   flags;
		int           beats; // payload beats between header and tail
		event_map_t   exp_ev;
		pkt_in_info_t exp_info;
		bit           exp_wr;
		conn_entry_t  exp_entry;
	} row_t;

	logic         clk;
	logic         reset;
	logic         meta_valid;
	meta_t        meta;
	logic         hash_valid;
	conn_idx_t    hash_1;
	conn_idx_t    hash_2;
	hash_entry_t  hash_entry_1;
	hash_entry_t  hash_entry_2;
	logic         conn_rd;
	logic         conn_wr;
	logic         aging_wr;
	conn_idx_t    conn_idx;
	conn_entry_t  conn_wdata;
	conn_read_t   conn_rdata;
	logic         event_valid;
	event_map_t   events;
	pkt_in_info_t pkt_in_info;

	row_t        rows [N_ROWS];
	int          results = 0;
	int          hash_count = 0; // searches started
	int          cycles = 0;
	int          ev_errors = 0;
	int          info_errors = 0;
	int          entry_errors = 0;
	int          other_errors = 0;
	logic        wr_seen = 1'b0; // table write since last result
	logic        aging_seen = 1'b0; // aging refresh since last result
	conn_entry_t wr_entry;

	connection_searcher #(.HASH_RD_LATENCY(2), .CONN_RD_LATENCY(3), .FIFO_DEPTH(32))
	connection_searcher_i (
		.clk, .reset, .meta_valid, .meta, .hash_valid, .hash_1, .hash_2, .hash_entry_1,
		.hash_entry_2, .conn_rd, .conn_wr, .aging_wr, .conn_idx, .conn_wdata, .conn_rdata,
		.event_valid, .events, .pkt_in_info
	);

	conn_table_model #(.hash_rd_latency(2), .conn_rd_latency(3)) table_model_i (
		.clk, .reset, .hash_1, .hash_2, .hash_entry_1, .hash_entry_2, .conn_rd, .conn_wr,
		.aging_wr, .conn_idx, .conn_wdata, .conn_rdata
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// host h gives ip .h to ip .h+1, ports with zero low bits so the bucket is the host byte
	function automatic flow_key_t host_key(input logic [7:0] h);
		return '{{24'h0a0000, h}, {24'h0a0000, h + 8'd1}, {h[6:0], 9'h000}, 16'h0a00};
	endfunction

	function automatic flow_key_t swap_dir(input flow_key_t k);
		return '{k.dst_ip, k.src_ip, k.dst_port, k.src_port}; // reply direction
	endfunction

	function automatic flow_key_t junk_key();
		return '{$urandom, $urandom, 16'($urandom), 16'($urandom)};
	endfunction

	function automatic conn_idx_t bucket_addr(input int which, input flow_key_t k);
		logic [15:0] f;
		f = (which == 1) ? (k.src_ip[15:0] ^ k.src_port) : (k.dst_ip[15:0] ^ k.dst_port);
		return f[8:0];
	endfunction

	function automatic sim_key_t short_key(input flow_key_t k);
		return k.src_ip[15:0] ^ k.dst_ip[15:0] ^ k.src_port ^ k.dst_port;
	endfunction

	function automatic conn_entry_t entry_of(input flow_key_t k, input logic dir,
			input tcp_state_e cli, input tcp_state_e ser, input conn_idx_t nxt);
		conn_entry_t e;
		e.flow_key = k;
		e.dir = dir;
		e.cli_state = cli;
		e.ser_state = ser;
		e.next_idx = nxt;
		return e;
	endfunction

	function automatic event_map_t new_flow_ev();
		event_map_t ev;
		ev = '0;
		ev.new_flow = 1'b1;
		ev.pkt_in = 1'b1;
		return ev;
	endfunction

	function automatic event_map_t hit_ev(input logic start, input logic fin, input logic setup);
		event_map_t ev;
		ev = '0;
		ev.every_pkt = 1'b1;
		ev.conn_start = start;
		ev.conn_end = fin;
		ev.conn_setup = setup;
		ev.state_change = start | fin | setup; // any transition
		return ev;
	endfunction

	function automatic pkt_in_info_t info_word(input conn_idx_t id, input logic dir,
			input tcp_state_e cli, input tcp_state_e ser, input event_map_t ev);
		return {7'd0, id, 3'd0, dir, cli, ser, ev[7:0]};
	endfunction

	function automatic meta_t make_beat(input logic [1:0] tag, input flow_key_t k,
			input tcp_flags_t f);
		meta_t b;
		b = '0;
		b.hd_tag = tag;
		b.flow_key = k;
		b.tcp_flags = f;
		b.rest = 26'($urandom);
		return b;
	endfunction

	task automatic place_bucket(input int which, input flow_key_t k, input conn_idx_t idx);
		table_model_i.write_bucket(which, bucket_addr(which, k),
			'{1'b1, short_key(k), 7'd0, idx});
	endtask

	task automatic preload_tables();
		table_model_i.write_conn(9'd5, 1'b0,
			entry_of(host_key(8'h11), 1'b0, REQUESTED, REQUESTED, '0));
		place_bucket(1, host_key(8'h11), 9'd5);
		table_model_i.write_conn(9'd7, 1'b0,
			entry_of(host_key(8'h21), 1'b0, REQUESTED, CLOSED, '0));
		place_bucket(1, swap_dir(host_key(8'h21)), 9'd7); // found by the reply packet
		table_model_i.write_conn(9'd9, 1'b0,
			entry_of(host_key(8'h31), 1'b0, ESTABLISHED, ESTABLISHED, '0));
		place_bucket(1, host_key(8'h31), 9'd9);
		table_model_i.write_conn(9'd11, 1'b0,
			entry_of(host_key(8'h41), 1'b0, ESTABLISHED, ESTABLISHED, 9'd12));
		table_model_i.write_conn(9'd12, 1'b0,
			entry_of(host_key(8'h51), 1'b0, REQUESTED, REQUESTED, '0));
		place_bucket(1, host_key(8'h51), 9'd11); // chain head holds another flow
		table_model_i.write_conn(9'd13, 1'b0,
			entry_of(host_key(8'h71), 1'b0, ESTABLISHED, ESTABLISHED, '0));
		place_bucket(2, host_key(8'h61), 9'd13); // bucket 2 only, chain ends unmatched
		table_model_i.write_conn(9'd15, 1'b1,
			entry_of(host_key(8'h81), 1'b0, ESTABLISHED, ESTABLISHED, '0));
		place_bucket(1, host_key(8'h81), 9'd15);
		table_model_i.write_conn(9'd17, 1'b0,
			entry_of(host_key(8'h91), 1'b1, ESTABLISHED, ESTABLISHED, '0));
		place_bucket(1, host_key(8'h91), 9'd17);
	endtask

	task automatic set_row(input int i, input string name, input flow_key_t key,
			input tcp_flags_t flags, input event_map_t ev, input pkt_in_info_t info,
			input bit wr, input conn_entry_t entry);
		rows[i].name = name;
		rows[i].key = key;
		rows[i].flags = flags;
		rows[i].beats = $urandom % 4; // 0 to 3 payload beats
		rows[i].exp_ev = ev;
		rows[i].exp_info = info;
		rows[i].exp_wr = wr;
		rows[i].exp_entry = entry;
	endtask

	task automatic build_rows();
		set_row(0, "hash_miss", host_key(8'h01), FLAG_ACK, new_flow_ev(),
			info_word('0, 1'b0, CLOSED, CLOSED, new_flow_ev()), 1'b0, '0);
		set_row(1, "ack_setup", host_key(8'h11), FLAG_ACK, hit_ev(1'b0, 1'b0, 1'b1),
			info_word(9'd5, 1'b0, ESTABLISHED, ESTABLISHED, hit_ev(1'b0, 1'b0, 1'b1)), 1'b1,
			entry_of(host_key(8'h11), 1'b0, ESTABLISHED, ESTABLISHED, '0));
		set_row(2, "synack_reverse", swap_dir(host_key(8'h21)), FLAG_SYN | FLAG_ACK,
			hit_ev(1'b1, 1'b0, 1'b0),
			info_word(9'd7, 1'b0, REQUESTED, REQUESTED, hit_ev(1'b1, 1'b0, 1'b0)), 1'b1,
			entry_of(host_key(8'h21), 1'b0, REQUESTED, REQUESTED, '0));
		set_row(3, "fin_client", host_key(8'h31), FLAG_FIN | FLAG_ACK, hit_ev(1'b0, 1'b1, 1'b0),
			info_word(9'd9, 1'b0, CLOSED, ESTABLISHED, hit_ev(1'b0, 1'b1, 1'b0)), 1'b1,
			entry_of(host_key(8'h31), 1'b0, CLOSED, ESTABLISHED, '0));
		set_row(4, "chain_walk", host_key(8'h51), FLAG_ACK, hit_ev(1'b0, 1'b0, 1'b1),
			info_word(9'd12, 1'b0, ESTABLISHED, ESTABLISHED, hit_ev(1'b0, 1'b0, 1'b1)), 1'b1,
			entry_of(host_key(8'h51), 1'b0, ESTABLISHED, ESTABLISHED, '0));
		set_row(5, "chain_end", host_key(8'h61), FLAG_ACK, new_flow_ev(),
			info_word('0, 1'b0, CLOSED, CLOSED, new_flow_ev()), 1'b0, '0);
		set_row(6, "aging_set", host_key(8'h81), FLAG_ACK, new_flow_ev(),
			info_word(9'd15, 1'b0, CLOSED, CLOSED, new_flow_ev()), 1'b0, '0);
		set_row(7, "no_transition", host_key(8'h91), FLAG_ACK, hit_ev(1'b0, 1'b0, 1'b0),
			info_word(9'd17, 1'b1, ESTABLISHED, ESTABLISHED, hit_ev(1'b0, 1'b0, 1'b0)), 1'b0, '0);
		set_row(8, "repeat_miss", host_key(8'h01), FLAG_SYN, new_flow_ev(),
			info_word('0, 1'b0, CLOSED, CLOSED, new_flow_ev()), 1'b0, '0);
		set_row(9, "repeat_aging", host_key(8'h81), FLAG_ACK, new_flow_ev(),
			info_word(9'd15, 1'b0, CLOSED, CLOSED, new_flow_ev()), 1'b0, '0); // tag still set
		set_row(10, "repeat_no_transition", host_key(8'h91), FLAG_ACK, hit_ev(1'b0, 1'b0, 1'b0),
			info_word(9'd17, 1'b1, ESTABLISHED, ESTABLISHED, hit_ev(1'b0, 1'b0, 1'b0)), 1'b0, '0);
	endtask

	task automatic drive_beat(input meta_t b);
		@(posedge clk);
		meta_valid <= 1'b1;
		meta <= b;
	endtask

	task automatic send_packet(input int i);
		drive_beat(make_beat(TAG_HEAD, rows[i].key, rows[i].flags));
		for (int b = 0; b < rows[i].beats; b++) begin
			drive_beat(make_beat(TAG_BODY, junk_key(), tcp_flags_t'($urandom))); // must not search
		end
		drive_beat(make_beat(PKT_TAIL, junk_key(), tcp_flags_t'($urandom)));
	endtask

	task automatic check_events(input string name, input event_map_t exp, input event_map_t act);
		if (exp !== act) begin
			$display("MISMATCH %s events: expected %h actual %h", name, exp, act);
			ev_errors++;
		end
	endtask

	task automatic check_info(input string name, input pkt_in_info_t exp, input pkt_in_info_t act);
		if (exp !== act) begin
			$display("MISMATCH %s pkt_in_info: expected %h actual %h", name, exp, act);
			info_errors++;
		end
	endtask

	task automatic check_entry(input string name, input conn_entry_t exp, input conn_entry_t act);
		if (exp !== act) begin
			$display("MISMATCH %s written entry: expected %h actual %h", name, exp, act);
			entry_errors++;
		end
	endtask

	task automatic check_result(input int i);
		check_events(rows[i].name, rows[i].exp_ev, events);
		check_info(rows[i].name, rows[i].exp_info, pkt_in_info);
		if (rows[i].exp_wr && !wr_seen) begin
			$display("%s: the connection table was not written", rows[i].name);
			other_errors++;
		end else if (!rows[i].exp_wr && wr_seen) begin
			$display("%s: the connection table was written though nothing changed", rows[i].name);
			other_errors++;
		end else if (rows[i].exp_wr) begin
			check_entry(rows[i].name, rows[i].exp_entry, wr_entry);
		end
		if (rows[i].exp_ev.every_pkt && !aging_seen) begin // live match refreshes the tag
			$display("%s: the aging tag of the matched entry was not refreshed", rows[i].name);
			other_errors++;
		end else if (!rows[i].exp_ev.every_pkt && aging_seen) begin
			$display("%s: the aging tag was refreshed without a live match", rows[i].name);
			other_errors++;
		end
	endtask

	always @(posedge clk) begin
		if (reset && hash_valid) begin
			hash_count++;
		end
		if (reset && event_valid) begin
			if (results < N_ROWS) begin
				check_result(results); // results come in arrival order
			end else begin
				$display("extra result after the last packet, events %h", events);
				other_errors++;
			end
			results++;
			wr_seen = 1'b0;
			aging_seen = 1'b0;
		end
		if (reset && conn_wr) begin
			wr_seen = 1'b1;
			wr_entry = conn_wdata;
		end
		if (reset && aging_wr) begin
			aging_seen = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: %0d of %0d results after %0d cycles", results, N_ROWS, cycles);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'hb51c7474));
		reset = 1'b0;
		meta_valid = 1'b0;
		meta = '0;
		build_rows();
		@(posedge clk);
		preload_tables(); // model arrays cleared at time 0
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		for (int i = 0; i < N_ROWS; i++) begin
			send_packet(i); // back to back, no idle beats
		end
		@(posedge clk);
		meta_valid <= 1'b0;
		wait (results == N_ROWS);
		repeat (40) @(posedge clk); // late extra results show up here
		if (hash_count != N_ROWS) begin
			$display("%0d searches started for %0d packets", hash_count, N_ROWS);
			other_errors++;
		end
		$display("errors: events %0d, info %0d, entry %0d, other %0d",
			ev_errors, info_errors, entry_errors, other_errors);
		if (ev_errors + info_errors + entry_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/connection_searcher.sv ====
// top level of the connection searcher, connects hasher, matcher, queues and table search
`timescale 1ns/1ps
`default_nettype none

module connection_searcher import conn_pkg::*; #(
	parameter int HASH_RD_LATENCY = 2,
	parameter int CONN_RD_LATENCY = 3,
	parameter int FIFO_DEPTH = 32
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              meta_valid,
	input  wire meta_t       meta,
	output logic             hash_valid,
	output conn_idx_t        hash_1,
	output conn_idx_t        hash_2,
	input  wire hash_entry_t hash_entry_1,
	input  wire hash_entry_t hash_entry_2,
	output logic             conn_rd,
	output logic             conn_wr,
	output logic             aging_wr,
	output conn_idx_t        conn_idx,
	output conn_entry_t      conn_wdata,
	input  wire conn_read_t  conn_rdata,
	output logic             event_valid,
	output event_map_t       events,
	output pkt_in_info_t     pkt_in_info
);

	sim_key_t   sim_key;
	key_rec_t   key_rec; // hasher side
	key_rec_t   key_head; // fifo head
	logic       idx_wr;
	conn_idx_t  idx_in;
	conn_idx_t  idx_head;
	logic       idx_empty;
	logic       fifo_rd;
	logic       timer_start;
	logic       timer_done;
	logic       upd_load;
	logic       upd_dir;
	tcp_flags_t upd_flags;
	logic       changed;
	event_map_t trans_events;

	flow_key_hasher flow_key_hasher_i (
		.clk, .reset, .meta_valid, .meta, .hash_valid, .hash_1, .hash_2, .sim_key, .key_rec
	);

	hash_matcher #(.hash_rd_latency(HASH_RD_LATENCY)) hash_matcher_i (
		.clk, .reset, .hash_valid, .sim_key, .hash_entry_1, .hash_entry_2,
		.idx_wr, .idx(idx_in)
	);

	sync_fifo #(.payload_t(key_rec_t), .depth(FIFO_DEPTH)) key_fifo (
		.clk, .reset, .wr(hash_valid), .wdata(key_rec), .rd(fifo_rd), .rdata(key_head), .empty()
	);

	sync_fifo #(.payload_t(conn_idx_t), .depth(FIFO_DEPTH)) idx_fifo (
		.clk, .reset, .wr(idx_wr), .wdata(idx_in), .rd(fifo_rd), .rdata(idx_head),
		.empty(idx_empty)
	);

	conn_search_fsm conn_search_fsm_i (
		.clk, .reset, .idx_empty, .idx(idx_head), .key_rec(key_head), .fifo_rd,
		.timer_start, .timer_done, .conn_rdata, .conn_rd, .conn_wr, .aging_wr, .conn_idx,
		.upd_load, .upd_dir, .upd_flags, .new_entry(conn_wdata), .changed, .trans_events,
		.event_valid, .events, .pkt_in_info
	);

	table_wait_timer #(.latency(CONN_RD_LATENCY)) table_wait_timer_i (
		.clk, .reset, .start(timer_start), .done(timer_done)
	);

	tcp_state_update tcp_state_update_i (
		.clk, .reset, .load(upd_load), .entry(conn_rdata.entry), .dir(upd_dir),
		.flags(upd_flags), .new_entry(conn_wdata), .changed, .trans_events
	);

endmodule

`default_nettype wire

// ==== hdl/flow_key_hasher.sv ====
// catches the header beat of each packet and registers the bucket hashes, short key and key record
`timescale 1ns/1ps
`default_nettype none

module flow_key_hasher import conn_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        meta_valid,
	input  wire meta_t meta,
	output logic       hash_valid,
	output conn_idx_t  hash_1,
	output conn_idx_t  hash_2,
	output sim_key_t   sim_key,
	output key_rec_t   key_rec
);

	typedef enum logic {st_idle, st_skip} hasher_state_e;

	hasher_state_e state;
	logic          is_header;
	logic          is_tail;
	logic [15:0]   fold_src; // src ip low half ^ src port
	logic [15:0]   fold_dst;

	assign is_header = meta_valid && (state == st_idle); // first beat after a tail
	assign is_tail = (meta.hd_tag == PKT_TAIL);
	assign fold_src = meta.flow_key.src_ip[15:0] ^ meta.flow_key.src_port;
	assign fold_dst = meta.flow_key.dst_ip[15:0] ^ meta.flow_key.dst_port;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			hash_valid <= 1'b0;
		end else begin
			hash_valid <= is_header; // one pulse per packet
			case (state)
				st_idle: if (meta_valid && !is_tail) state <= st_skip; // single-beat pkt stays
				st_skip: if (meta_valid && is_tail) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (is_header) begin
			hash_1 <= fold_src[8:0];
			hash_2 <= fold_dst[8:0];
			sim_key <= fold_src ^ fold_dst; // all four 16-bit parts
			key_rec <= '{meta.flow_key, meta.tcp_flags};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/hash_matcher.sv ====
// waits out the hash-table read and turns the two returned buckets into a connection index
`timescale 1ns/1ps
`default_nettype none

module hash_matcher import conn_pkg::*; #(
	parameter int hash_rd_latency = 2
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              hash_valid,
	input  wire sim_key_t    sim_key,
	input  wire hash_entry_t hash_entry_1,
	input  wire hash_entry_t hash_entry_2,
	output logic             idx_wr,
	output conn_idx_t        idx
);

	logic [hash_rd_latency-1:0] vld_pipe; // lookup in flight
	sim_key_t                   key_pipe [hash_rd_latency];
	sim_key_t                   key_now;
	logic                       hit_1;
	logic                       hit_2;

	assign key_now = key_pipe[hash_rd_latency-1]; // lines up with bucket data
	assign hit_1 = hash_entry_1.valid && (hash_entry_1.sim_key == key_now);
	assign hit_2 = hash_entry_2.valid && (hash_entry_2.sim_key == key_now);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			vld_pipe <= '0;
			idx_wr <= 1'b0;
		end else begin
			vld_pipe[0] <= hash_valid;
			for (int i = 1; i < hash_rd_latency; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
			end
			idx_wr <= vld_pipe[hash_rd_latency-1]; // hit or miss, always one write
		end
	end

	always_ff @(posedge clk) begin
		key_pipe[0] <= sim_key;
		for (int i = 1; i < hash_rd_latency; i++) begin
			key_pipe[i] <= key_pipe[i-1];
		end
		if (vld_pipe[hash_rd_latency-1]) begin
			if (hit_1) idx <= hash_entry_1.idx; // bucket 1 wins
			else if (hit_2) idx <= hash_entry_2.idx;
			else idx <= '0; // miss
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
// show-ahead synchronous FIFO for any packed payload, used for the key and index queues
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth = 32
) (
	input  wire           clk,
	input  wire           reset,
	input  wire           wr,
	input  wire payload_t wdata,
	input  wire           rd,
	output payload_t      rdata,
	output logic          empty
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;

	payload_t      mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0]   count; // words stored
	logic          full;

	function automatic logic [aw-1:0] next_ptr(logic [aw-1:0] p);
		return (p == aw'(depth - 1)) ? '0 : p + 1'b1; // wraps for any depth
	endfunction

	assign rdata = mem[rd_ptr]; // head word visible without a read
	assign empty = (count == '0);
	assign full = (count == (aw + 1)'(depth));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr) wr_ptr <= next_ptr(wr_ptr);
			if (rd) rd_ptr <= next_ptr(rd_ptr);
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr) mem[wr_ptr] <= wdata;
	end

	// upstream ran too far ahead of the search, or a pop without data
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset)
		!(wr && full) && !(rd && empty));

endmodule

`default_nettype wire
